// File: hw/pe_pkg.sv
/*
 * pe_pkg
 * Shared constants and the opcode encoding for the modular
 * arithmetic PE array over q = 3329.
 */
package pe_pkg;

    // modulus and datapath widths
    localparam int COEF_W = 12;
    localparam int PROD_W = 2 * COEF_W;
    localparam logic [COEF_W-1:0] Q = 12'd3329;

    localparam int NUM_LANES = 4;

    // pipeline depths
    localparam int MUL_LAT = 3;
    localparam int ADD_LAT = 1;
    localparam int PE_LAT = MUL_LAT + ADD_LAT;

    // Barrett reduction, floor(2^24 / q)
    // must be recomputed together with Q
    localparam logic [12:0] BARRETT_M = 13'd5039;
    localparam int BARRETT_SHIFT = 24;

    typedef enum logic [2:0] {
        OP_MADD   = 3'd0,
        OP_MSUB   = 3'd1,
        OP_MMUL   = 3'd2,
        OP_CT_BFO = 3'd3,
        OP_GS_BFO = 3'd4
    } pe_op_t;

endpackage

// File: hw/mod_add_sub.sv
/*
 * mod_add_sub
 * Registered modular adder and subtractor, one cycle.
 * Produces (x + y) mod q and (x - y) mod q together.
 */
module mod_add_sub (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [pe_pkg::COEF_W-1:0] x,
    input  logic [pe_pkg::COEF_W-1:0] y,
    output logic [pe_pkg::COEF_W-1:0] sum,
    output logic [pe_pkg::COEF_W-1:0] diff
);
    import pe_pkg::*;

    logic [COEF_W:0]   sum_raw;
    logic [COEF_W:0]   diff_raw;
    logic [COEF_W-1:0] sum_red;
    logic [COEF_W-1:0] diff_red;

    // carry bit kept so the compare sees the full sum
    assign sum_raw = {1'b0, x} + {1'b0, y};
    assign sum_red = (sum_raw >= {1'b0, Q}) ? sum_raw[COEF_W-1:0] - Q
                                             : sum_raw[COEF_W-1:0];

    // top bit is the borrow
    assign diff_raw = {1'b0, x} - {1'b0, y};
    assign diff_red = diff_raw[COEF_W] ? diff_raw[COEF_W-1:0] + Q
                                       : diff_raw[COEF_W-1:0];

    always_ff @(posedge clk) begin
        sum  <= sum_red;
        diff <= diff_red;
    end

    // operands below q keep both results reduced
    result_reduced: assert property (
        @(posedge clk) disable iff (rst)
        (sum < Q) && (diff < Q)
    );

endmodule

// File: hw/mod_mul.sv
/*
 * mod_mul
 * Three-stage modular multiplier with Barrett reduction.
 * Stage 1 product, stage 2 quotient estimate, stage 3 correction.
 */
module mod_mul (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [pe_pkg::COEF_W-1:0] x,
    input  logic [pe_pkg::COEF_W-1:0] y,
    output logic [pe_pkg::COEF_W-1:0] prod
);
    import pe_pkg::*;

    localparam int MQ_W = PROD_W + $bits(BARRETT_M);

    // stage 1
    logic [PROD_W-1:0] p1;

    // stage 2
    logic [MQ_W-1:0]   mq;
    logic [PROD_W-1:0] p2;
    logic [COEF_W-1:0] q_est;

    // stage 3
    logic [PROD_W-1:0] r0;
    logic [PROD_W-1:0] r1;
    logic [PROD_W-1:0] r2;

    always_ff @(posedge clk) begin
        p1 <= x * y;
    end

    // estimate never exceeds the true quotient
    assign mq = p1 * BARRETT_M;

    always_ff @(posedge clk) begin
        p2    <= p1;
        q_est <= mq[BARRETT_SHIFT +: COEF_W];
    end

    // remainder below 3q, at most two corrections
    assign r0 = p2 - q_est * Q;
    assign r1 = (r0 >= Q) ? r0 - Q : r0;
    assign r2 = (r1 >= Q) ? r1 - Q : r1;

    always_ff @(posedge clk) begin
        prod <= r2[COEF_W-1:0];
    end

    // an off-by-more estimate would leave 3q or above here
    prod_reduced: assert property (
        @(posedge clk) disable iff (rst)
        prod < Q
    );

endmodule

// File: hw/pe_lane.sv
/*
 * pe_lane
 * One processing element. Routes operands through a pre adder,
 * the Barrett multiplier and a post adder by opcode, and aligns
 * every result to the common PE latency.
 */
module pe_lane (
    input  logic                      clk,
    input  logic                      rst,
    input  pe_pkg::pe_op_t            op,
    input  logic [pe_pkg::COEF_W-1:0] a,
    input  logic [pe_pkg::COEF_W-1:0] b,
    input  logic [pe_pkg::COEF_W-1:0] w,
    output logic [pe_pkg::COEF_W-1:0] out0,
    output logic [pe_pkg::COEF_W-1:0] out1
);
    import pe_pkg::*;

    pe_op_t            op_d  [1:PE_LAT];
    logic [COEF_W-1:0] a_d   [1:MUL_LAT];
    logic [COEF_W-1:0] pre_d [1:MUL_LAT];

    logic [COEF_W-1:0] gs_diff;
    logic [COEF_W-1:0] mul_x;
    logic [COEF_W-1:0] mul_y;
    logic [COEF_W-1:0] mul_p;
    logic [COEF_W-1:0] mul_p_d;

    logic [COEF_W-1:0] pre_sum;
    logic [COEF_W-1:0] pre_diff;
    logic [COEF_W-1:0] pre_res;
    logic [COEF_W-1:0] post_sum;
    logic [COEF_W-1:0] post_diff;

    // GS difference formed ahead of the pre adder so that every
    // multiply starts in the issue cycle and never collides
    assign gs_diff = (a >= b) ? a - b : a - b + Q;

    always_comb begin
        case (op)
            OP_CT_BFO: begin
                mul_x = b;
                mul_y = w;
            end
            OP_GS_BFO: begin
                mul_x = gs_diff;
                mul_y = w;
            end
            default: begin
                mul_x = a;
                mul_y = b;
            end
        endcase
    end

    mod_add_sub u_pre (
        .clk  (clk),
        .rst  (rst),
        .x    (a),
        .y    (b),
        .sum  (pre_sum),
        .diff (pre_diff)
    );

    mod_mul u_mul (
        .clk  (clk),
        .rst  (rst),
        .x    (mul_x),
        .y    (mul_y),
        .prod (mul_p)
    );

    // post adder only matters for CT, a and t meet in cycle 3
    mod_add_sub u_post (
        .clk  (clk),
        .rst  (rst),
        .x    (a_d[MUL_LAT]),
        .y    (mul_p),
        .sum  (post_sum),
        .diff (post_diff)
    );

    // opcode travels alongside its data
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k <= PE_LAT; k++) begin
                op_d[k] <= OP_MADD;
            end
        end else begin
            op_d[1] <= op;
            for (int k = 2; k <= PE_LAT; k++) begin
                op_d[k] <= op_d[k-1];
            end
        end
    end

    // MSUB keeps the difference, all others the sum
    assign pre_res = (op_d[1] == OP_MSUB) ? pre_diff : pre_sum;

    always_ff @(posedge clk) begin
        a_d[1]   <= a;
        pre_d[1] <= pre_res;
        for (int k = 2; k <= MUL_LAT; k++) begin
            a_d[k]   <= a_d[k-1];
            pre_d[k] <= pre_d[k-1];
        end
        mul_p_d <= mul_p;
    end

    always_comb begin
        case (op_d[PE_LAT])
            OP_CT_BFO: begin
                out0 = post_sum;
                out1 = post_diff;
            end
            OP_MMUL: begin
                out0 = mul_p_d;
                out1 = mul_p_d;
            end
            default: begin
                // MADD, MSUB and GS
                out0 = pre_d[MUL_LAT];
                out1 = mul_p_d;
            end
        endcase
    end

endmodule

// File: hw/pe_array.sv
/*
 * pe_array
 * Top level of the four-lane modular arithmetic PE array.
 * Broadcasts the opcode to all lanes and tracks valid issues.
 */
module pe_array (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  pe_pkg::pe_op_t            op,
    input  logic [pe_pkg::COEF_W-1:0] a    [pe_pkg::NUM_LANES],
    input  logic [pe_pkg::COEF_W-1:0] b    [pe_pkg::NUM_LANES],
    input  logic [pe_pkg::COEF_W-1:0] w    [pe_pkg::NUM_LANES],
    output logic                      out_valid,
    output logic [pe_pkg::COEF_W-1:0] out0 [pe_pkg::NUM_LANES],
    output logic [pe_pkg::COEF_W-1:0] out1 [pe_pkg::NUM_LANES]
);
    import pe_pkg::*;

    logic [PE_LAT-1:0] valid_sr;
    pe_op_t            lane_op;

    // idle cycles feed zeros through the lanes
    assign lane_op = in_valid ? op : OP_MADD;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[PE_LAT-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[PE_LAT-1];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [COEF_W-1:0] a_q;
        logic [COEF_W-1:0] b_q;
        logic [COEF_W-1:0] w_q;

        assign a_q = in_valid ? a[i] : '0;
        assign b_q = in_valid ? b[i] : '0;
        assign w_q = in_valid ? w[i] : '0;

        pe_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .op   (lane_op),
            .a    (a_q),
            .b    (b_q),
            .w    (w_q),
            .out0 (out0[i]),
            .out1 (out1[i])
        );
    end

    // each issue comes back exactly once at the fixed latency
    issue_returns: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> ##PE_LAT out_valid
    );

endmodule

// File: testbench/pe_model.svh
/*
 * pe_model
 * Reference arithmetic for the PE array operations, all mod q.
 */
`ifndef PE_MODEL_SVH
`define PE_MODEL_SVH

function automatic int add_mod(input int x, input int y);
    int qv;
    qv = int'(Q);
    return (x + y) % qv;
endfunction

function automatic int sub_mod(input int x, input int y);
    int qv;
    qv = int'(Q);
    return (x - y + qv) % qv;
endfunction

function automatic int mul_mod(input int x, input int y);
    int qv;
    qv = int'(Q);
    return (x * y) % qv;
endfunction

// r1 only meaningful for the two butterflies
function automatic void model_op(input pe_op_t o, input int a, input int b, input int w,
                                 output int r0, output int r1, output bit has1);
    int t;
    r0 = 0;
    r1 = 0;
    has1 = 1'b0;
    case (o)
        OP_MADD: r0 = add_mod(a, b);
        OP_MSUB: r0 = sub_mod(a, b);
        OP_MMUL: r0 = mul_mod(a, b);
        OP_CT_BFO: begin
            t = mul_mod(b, w);
            r0 = add_mod(a, t);
            r1 = sub_mod(a, t);
            has1 = 1'b1;
        end
        OP_GS_BFO: begin
            r0 = add_mod(a, b);
            r1 = mul_mod(sub_mod(a, b), w);
            has1 = 1'b1;
        end
        default: r0 = 0;
    endcase
endfunction

function automatic string op_label(input pe_op_t o);
    case (o)
        OP_MADD:   return "MADD";
        OP_MSUB:   return "MSUB";
        OP_MMUL:   return "MMUL";
        OP_CT_BFO: return "CT_BFO";
        OP_GS_BFO: return "GS_BFO";
        default:   return "UNKNOWN";
    endcase
endfunction

`endif

// File: testbench/tb_pe_array.sv
/*
 * tb_pe_array
 * Random testbench for the PE array. Issues operations from an LFSR
 * and checks every lane against the reference model in issue order.
 */
module tb_pe_array;
    import pe_pkg::*;

    `include "pe_model.svh"

    localparam logic [31:0] SEED = 32'h63e24ff9;
    localparam int PHASE_LEN = 200;
    localparam int DRAIN_LIMIT = 4 * PE_LAT;

    localparam int MODE_IDLE = 0;
    localparam int MODE_BASIC = 1;
    localparam int MODE_CT = 2;
    localparam int MODE_GS = 3;
    localparam int MODE_MIXED = 4;
    localparam int MODE_GAPS = 5;

    logic              clk;
    logic              rst;
    logic              in_valid;
    pe_op_t            op;
    logic [COEF_W-1:0] a    [NUM_LANES];
    logic [COEF_W-1:0] b    [NUM_LANES];
    logic [COEF_W-1:0] w    [NUM_LANES];
    logic              out_valid;
    logic [COEF_W-1:0] out0 [NUM_LANES];
    logic [COEF_W-1:0] out1 [NUM_LANES];

    logic [31:0] lfsr;
    int          cycle;
    int          issue_count;
    int          result_count;

    // pending issues, lane results stored NUM_LANES entries per issue
    string name_q  [$];
    int    issue_q [$];
    bit    has1_q  [$];
    int    exp0_q  [$];
    int    exp1_q  [$];

    pe_array DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .w         (w),
        .out_valid (out_valid),
        .out0      (out0),
        .out1      (out1)
    );

    always #4 clk = ~clk;

    // right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // edge values 0 and q-1 come up often
    task automatic draw_operand(output logic [COEF_W-1:0] v);
        int sel;
        int r;
        draw_bits(3, sel);
        if (sel == 0) begin
            v = '0;
        end else if (sel == 1) begin
            v = Q - 1;
        end else begin
            draw_bits(COEF_W, r);
            while (r >= int'(Q)) begin
                draw_bits(COEF_W, r);
            end
            v = r[COEF_W-1:0];
        end
    endtask

    task automatic draw_opcode(input int mode, output pe_op_t o);
        int r;
        if (mode == MODE_CT) begin
            o = OP_CT_BFO;
        end else if (mode == MODE_GS) begin
            o = OP_GS_BFO;
        end else begin
            draw_bits(3, r);
            while (r > 4 || (mode == MODE_BASIC && r > 2)) begin
                draw_bits(3, r);
            end
            o = pe_op_t'(r);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_outputs();
        string name;
        int    issued;
        bit    has1;
        int    e0;
        int    e1;
        if ($isunknown(out_valid)) begin
            abort_run("out_valid is unknown after reset");
        end
        if (out_valid) begin
            if (name_q.size() == 0) begin
                abort_run("out_valid pulsed with no operation in flight");
            end
            name = name_q.pop_front();
            issued = issue_q.pop_front();
            has1 = has1_q.pop_front();
            check_value($sformatf("%s latency", name), PE_LAT, cycle - issued);
            for (int i = 0; i < NUM_LANES; i++) begin
                e0 = exp0_q.pop_front();
                e1 = exp1_q.pop_front();
                check_value($sformatf("%s lane %0d out0", name, i), e0, out0[i]);
                if (has1) begin
                    check_value($sformatf("%s lane %0d out1", name, i), e1, out1[i]);
                end
            end
            result_count++;
        end
    endtask

    task automatic drive_next(input int mode);
        int     v;
        int     r0;
        int     r1;
        bit     has1;
        pe_op_t o;
        draw_opcode(mode, o);
        op = o;
        for (int i = 0; i < NUM_LANES; i++) begin
            draw_operand(a[i]);
            draw_operand(b[i]);
            draw_operand(w[i]);
        end
        if (mode == MODE_IDLE) begin
            in_valid = 1'b0;
        end else if (mode == MODE_GAPS) begin
            draw_bits(2, v);
            in_valid = (v != 0);
        end else begin
            in_valid = 1'b1;
        end
        if (in_valid) begin
            // in_valid is high during this cycle
            name_q.push_back(op_label(o));
            issue_q.push_back(cycle);
            has1_q.push_back(1'b0);
            for (int i = 0; i < NUM_LANES; i++) begin
                model_op(o, int'(a[i]), int'(b[i]), int'(w[i]), r0, r1, has1);
                exp0_q.push_back(r0);
                exp1_q.push_back(r1);
            end
            has1_q[has1_q.size() - 1] = has1;
            issue_count++;
        end
    endtask

    task automatic step_cycle(input int mode);
        @(posedge clk);
        #1;
        cycle++;
        check_outputs();
        drive_next(mode);
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (name_q.size() != 0 && waited < DRAIN_LIMIT) begin
            step_cycle(MODE_IDLE);
            waited++;
        end
        if (name_q.size() != 0) begin
            abort_run("results still missing after the drain timeout");
        end
        // no stray pulses once the pipeline is empty
        repeat (PE_LAT + 2) step_cycle(MODE_IDLE);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        op = OP_MADD;
        for (int i = 0; i < NUM_LANES; i++) begin
            a[i] = '0;
            b[i] = '0;
            w[i] = '0;
        end
        lfsr = SEED;
        cycle = 0;
        issue_count = 0;
        result_count = 0;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            step_cycle(MODE_IDLE);
            check_value("idle out_valid", 0, out_valid);
        end

        for (int mode = MODE_BASIC; mode <= MODE_GAPS; mode++) begin
            repeat (PHASE_LEN) step_cycle(mode);
        end

        drain_pipeline();

        if (result_count == issue_count && name_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d operations issued but %0d results seen",
                                issue_count, result_count));
        end
    end

endmodule

// File: verilog.f
+incdir+testbench
hw/pe_pkg.sv
hw/mod_add_sub.sv
hw/mod_mul.sv
hw/pe_lane.sv
hw/pe_array.sv
testbench/tb_pe_array.sv

// File: Bender.yml
package:
  name: pe_array

sources:
  - files:
      - hw/pe_pkg.sv
      - hw/mod_add_sub.sv
      - hw/mod_mul.sv
      - hw/pe_lane.sv
      - hw/pe_array.sv

  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_pe_array.sv
